// File: common/tut_board_cfg.svh
/* Board configuration macros
   CPU bus widths, memory sizes, ROM bank count and memory-map bases */

`ifndef TUT_BOARD_CFG_SVH
`define TUT_BOARD_CFG_SVH

//============================================================
// Bus and memory geometry
//============================================================
`define TUT_ADDR_W      16      // MC6809E address bus
`define TUT_DATA_W      8       // Byte-wide data bus
`define TUT_WRAM_AW     11      // 2 KB work RAM
`define TUT_PAL_AW      4       // 16-entry palette
`define TUT_BANK_AW     12      // 4 KB bank window
`define TUT_BANK_SEL_W  4       // Bank number field, top nibble of ROM address
`define TUT_BANK_CNT    9       // Banks actually fitted on the board
`define TUT_OPEN_BUS    8'hFF   // Pulled-up data bus

//============================================================
// Memory map bases
//============================================================
// Large windows
`define TUT_WRAM_BASE     16'h8000  // 0x8000-0x87FF, shared with the I/O block
`define TUT_WRAM2_BASE    16'h8800  // 0x8800-0x8FFF
`define TUT_BANKROM_BASE  16'h9000  // 0x9000-0x9FFF banked window

// I/O windows inside work RAM space, these win over RAM
`define TUT_PAL_BASE      16'h8000  // Palette RAM, 16 bytes
`define TUT_SCROLL_BASE   16'h8100  // Scroll register
`define TUT_WDOG_BASE     16'h8120  // Watchdog, reads open bus
`define TUT_DSW2_BASE     16'h8160
`define TUT_IN0_BASE      16'h8180  // Coins and start
`define TUT_IN1_BASE      16'h81A0  // Player 1
`define TUT_IN2_BASE      16'h81C0  // Player 2
`define TUT_DSW1_BASE     16'h81E0
`define TUT_LATCH_BASE    16'h8200  // Main latch, 0x8200-0x820F
`define TUT_BANKSEL_BASE  16'h8300  // ROM bank select
`define TUT_SNDCMD_BASE   16'h8700  // Sound command strobe

`endif

// File: common/tut_bus_pkg.sv
/* CPU-side bus types
   CPU bus, ROM download port, E/Q clock pair and sound board strobes */

`include "tut_board_cfg.svh"

package tut_bus_pkg;

	// One CPU bus cycle as seen by the board
	typedef struct packed {
		logic [`TUT_ADDR_W-1:0] addr;   // Address
		logic [`TUT_DATA_W-1:0] wdata;  // CPU write data
		logic                   rnw;    // 1 = read, 0 = write
	} cpu_bus_t;

	// ROM download port, one byte per strobe
	typedef struct packed {
		logic [`TUT_ADDR_W-1:0] addr;   // Bank in [15:12], offset in [11:0]
		logic [`TUT_DATA_W-1:0] data;
		logic                   wr;     // Write strobe
	} dl_port_t;

	// MC6809E quadrature clocks
	typedef struct packed {
		logic e;
		logic q;                        // Lags E by a quarter period
	} cpu_clk_t;

	// Lines to the sound board
	typedef struct packed {
		logic cmd;                      // Sound command write strobe
		logic irq;                      // Sound CPU IRQ trigger
	} sound_t;

endpackage

// File: common/tut_map_pkg.sv
/* Memory-map types
   Decoded chip selects and main control latch state */

`include "tut_board_cfg.svh"

package tut_map_pkg;

	// Decoded selects, at most one set per cycle
	typedef struct packed {
		logic wram;       // Work RAM, only where no I/O window hits
		logic wram2;      // Work RAM 2
		logic bank_rom;   // Banked ROM window
		logic pal;        // Palette RAM
		logic scroll;     // Scroll register
		logic dsw1;
		logic dsw2;
		logic in0;
		logic in1;
		logic in2;
		logic latch;      // Main latch, writes only
		logic bank_sel;   // Bank select, writes only
		logic snd_cmd;    // Sound command, writes only
	} sel_t;

	// Board control state driven by the main latch and scroll register
	typedef struct packed {
		logic                   nmi_mask;  // 1 = VBlank NMI enabled
		logic                   flip;      // Screen flip
		logic                   pix_en;    // Pixel output enable
		logic [`TUT_DATA_W-1:0] scroll;
	} board_ctrl_t;

endpackage

// File: verilog/tut_clock_gen.sv
/* Master clock divider
   Pixel and CPU clock enables, MC6809E E/Q quadrature with pause */

`timescale 1ns/1ps

module tut_clock_gen import tut_bus_pkg::*; (
	input  logic     clk_49m,     // 49.152 MHz master
	input  logic     reset,
	input  logic     pause_i,     // Freezes E/Q, divider keeps running
	output logic     cen_6m_o,    // 6.144 MHz enable
	output logic     cen_3m_o,    // 3.072 MHz enable
	output cpu_clk_t cpu_clk_o
);

	logic [3:0] div_q;            // 16-clock master divider
	cpu_clk_t   eq_q;

	// Divider starts from zero so enable phases are fixed after reset
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			div_q <= '0;
		end else begin
			div_q <= div_q + 4'd1;
		end
	end

	assign cen_6m_o = (div_q[2:0] == 3'd0);  // Every 8 clocks
	assign cen_3m_o = (div_q == 4'd0);       // Every 16 clocks

	// E/Q quadrature, Q steps a quarter period behind E
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			eq_q <= '0;
		end else if (!pause_i) begin
			case (div_q)
				4'd0:    eq_q <= '{e: 1'b1, q: 1'b0};
				4'd4:    eq_q <= '{e: 1'b1, q: 1'b1};
				4'd8:    eq_q <= '{e: 1'b0, q: 1'b1};
				4'd12:   eq_q <= '{e: 1'b0, q: 1'b0};
				default: ;                          // Hold between steps
			endcase
		end
	end

	assign cpu_clk_o = eq_q;

	// With a full quarter period unpaused, E and Q never move on the same edge
	a_eq_step: assert property (@(posedge clk_49m) disable iff (!reset)
		(!pause_i)[*5] |=> !($changed(eq_q.e) && $changed(eq_q.q)));

endmodule

// File: memory/tut_sync_ram.sv
/* Single-port byte RAM
   Synchronous write and registered read, depth set by address width */

`timescale 1ns/1ps

`include "tut_board_cfg.svh"

module tut_sync_ram #(
	parameter int ADDR_W = 11                // 2**ADDR_W bytes
) (
	input  logic                   clk_49m,
	input  logic                   we_i,     // Write enable, every active clock
	input  logic [ADDR_W-1:0]      addr_i,
	input  logic [`TUT_DATA_W-1:0] wdata_i,
	output logic [`TUT_DATA_W-1:0] rdata_o   // Valid one clock after addr_i
);

	localparam int DEPTH = 2 ** ADDR_W;

	logic [`TUT_DATA_W-1:0] mem [DEPTH];
	logic [`TUT_DATA_W-1:0] rdata_q;

	// Write port
	always_ff @(posedge clk_49m) begin
		if (we_i) begin
			mem[addr_i] <= wdata_i;
		end
	end

	// Registered read, returns old contents on a write cycle
	always_ff @(posedge clk_49m) begin
		rdata_q <= mem[addr_i];
	end

	assign rdata_o = rdata_q;

endmodule

// File: memory/tut_bank_rom.sv
/* Banked graphics ROM
   Nine 4 KB banks in one array, download write port, CPU bank-window read */

`timescale 1ns/1ps

`include "tut_board_cfg.svh"

module tut_bank_rom import tut_bus_pkg::*; (
	input  logic                       clk_49m,
	input  dl_port_t                   dl_i,      // Download port, wins over CPU
	input  logic [`TUT_BANK_SEL_W-1:0] bank_i,    // Bank select register
	input  logic [`TUT_BANK_AW-1:0]    offset_i,  // CPU address within window
	output logic [`TUT_DATA_W-1:0]     rdata_o
);

	localparam int ROM_AW = `TUT_BANK_SEL_W + `TUT_BANK_AW;  // 64 KB address space

	logic [ROM_AW-1:0]      rom_addr;
	logic [`TUT_DATA_W-1:0] rom_q;
	logic                   oor_q;                 // Unfitted bank selected

	//============================================================
	// Address source
	//============================================================
	// Download strobe steals the port for that clock
	always_comb begin
		if (dl_i.wr) begin
			rom_addr = dl_i.addr;                       // Bank in top nibble
		end else begin
			rom_addr = {bank_i, offset_i};
		end
	end

	tut_sync_ram #(
		.ADDR_W (ROM_AW)
	) rom_array_i (
		.clk_49m (clk_49m),
		.we_i    (dl_i.wr),
		.addr_i  (rom_addr),
		.wdata_i (dl_i.data),
		.rdata_o (rom_q)
	);

	//============================================================
	// Bank range check
	//============================================================
	// Registered to line up with the RAM read data
	always_ff @(posedge clk_49m) begin
		oor_q <= (bank_i >= `TUT_BANK_CNT);
	end

	// Banks 9-15 have no ROM fitted, bus floats high
	assign rdata_o = oor_q ? `TUT_OPEN_BUS : rom_q;

endmodule

// File: verilog/tut_bus_decode.sv
/* Memory-map decoder
   Chip selects with I/O priority over work RAM, registered CPU read mux */

`timescale 1ns/1ps

`include "tut_board_cfg.svh"

module tut_bus_decode import tut_bus_pkg::*, tut_map_pkg::*; (
	input  logic                       clk_49m,
	input  logic                       reset,
	input  cpu_bus_t                   bus_i,
	input  logic [2*`TUT_DATA_W-1:0]   dip_sw_i,   // DSW2 high byte, DSW1 low byte
	input  logic [`TUT_DATA_W-1:0]     scroll_i,
	input  logic [`TUT_DATA_W-1:0]     wram_d_i,
	input  logic [`TUT_DATA_W-1:0]     wram2_d_i,
	input  logic [`TUT_DATA_W-1:0]     pal_d_i,
	input  logic [`TUT_DATA_W-1:0]     bank_d_i,
	output sel_t                       sel_o,
	output logic [`TUT_DATA_W-1:0]     rd_data_o
);

	// Read source codes
	localparam logic [2:0] SRC_REG   = 3'd0;  // Registered value below
	localparam logic [2:0] SRC_WRAM  = 3'd1;
	localparam logic [2:0] SRC_WRAM2 = 3'd2;
	localparam logic [2:0] SRC_PAL   = 3'd3;
	localparam logic [2:0] SRC_BANK  = 3'd4;

	logic [`TUT_ADDR_W-1:0] a;
	logic                   wr;
	logic                   latch_hit, bank_hit, snd_hit, wdog_hit;
	logic                   io_win;               // Any I/O window inside work RAM space
	sel_t                   sel;
	logic [2:0]             src, src_q;
	logic [`TUT_DATA_W-1:0] reg_val, reg_val_q;

	// Window compare on the bits above lsb
	function automatic logic hit(input logic [`TUT_ADDR_W-1:0] addr,
	                             input logic [`TUT_ADDR_W-1:0] base,
	                             input int unsigned lsb);
		hit = ((addr >> lsb) == (base >> lsb));
	endfunction

	assign a  = bus_i.addr;
	assign wr = !bus_i.rnw;

	//============================================================
	// Chip selects
	//============================================================
	assign latch_hit = hit(a, `TUT_LATCH_BASE, 4);     // 8 latch bits on A3-A1
	assign bank_hit  = hit(a, `TUT_BANKSEL_BASE, 8);
	assign snd_hit   = hit(a, `TUT_SNDCMD_BASE, 8);
	assign wdog_hit  = hit(a, `TUT_WDOG_BASE, 4);      // Reads open bus

	always_comb begin
		sel          = '0;
		sel.pal      = hit(a, `TUT_PAL_BASE, `TUT_PAL_AW);
		sel.scroll   = hit(a, `TUT_SCROLL_BASE, 4);
		sel.dsw2     = hit(a, `TUT_DSW2_BASE, 4);
		sel.in0      = hit(a, `TUT_IN0_BASE, 4);
		sel.in1      = hit(a, `TUT_IN1_BASE, 4);
		sel.in2      = hit(a, `TUT_IN2_BASE, 4);
		sel.dsw1     = hit(a, `TUT_DSW1_BASE, 4);
		sel.latch    = latch_hit & wr;                  // Write-only registers
		sel.bank_sel = bank_hit & wr;
		sel.snd_cmd  = snd_hit & wr;
		sel.wram2    = hit(a, `TUT_WRAM2_BASE, `TUT_WRAM_AW);
		sel.bank_rom = hit(a, `TUT_BANKROM_BASE, `TUT_BANK_AW);
		// I/O windows mask work RAM for reads and writes alike
		sel.wram     = hit(a, `TUT_WRAM_BASE, `TUT_WRAM_AW) & !io_win;
	end

	assign io_win = sel.pal | sel.scroll | sel.dsw1 | sel.dsw2 | sel.in0 | sel.in1
	              | sel.in2 | latch_hit | bank_hit | snd_hit | wdog_hit;

	assign sel_o = sel;

	//============================================================
	// Read data
	//============================================================
	always_comb begin
		if (sel.wram)          src = SRC_WRAM;
		else if (sel.wram2)    src = SRC_WRAM2;
		else if (sel.pal)      src = SRC_PAL;
		else if (sel.bank_rom) src = SRC_BANK;
		else                   src = SRC_REG;
	end

	// Register-type sources, IN0-IN2, watchdog and unmapped all float high
	always_comb begin
		if (sel.scroll)        reg_val = scroll_i;
		else if (sel.dsw1)     reg_val = ~dip_sw_i[`TUT_DATA_W-1:0];        // Active low
		else if (sel.dsw2)     reg_val = ~dip_sw_i[2*`TUT_DATA_W-1:`TUT_DATA_W];
		else                   reg_val = `TUT_OPEN_BUS;
	end

	// One clock of delay to match the synchronous RAMs
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			src_q <= SRC_REG;
		end else begin
			src_q <= src;
		end
	end

	always_ff @(posedge clk_49m) begin
		reg_val_q <= reg_val;
	end

	always_comb begin
		case (src_q)
			SRC_WRAM:  rd_data_o = wram_d_i;
			SRC_WRAM2: rd_data_o = wram2_d_i;
			SRC_PAL:   rd_data_o = pal_d_i;
			SRC_BANK:  rd_data_o = bank_d_i;
			default:   rd_data_o = reg_val_q;
		endcase
	end

	// Windows are disjoint after the I/O priority masking
	a_sel_onehot: assert property (@(posedge clk_49m) disable iff (!reset)
		$onehot0(sel));

endmodule

// File: verilog/tut_io_regs.sv
/* Board control registers
   Bank select, scroll, main latch, VBlank NMI and sound IRQ/command */

`timescale 1ns/1ps

`include "tut_board_cfg.svh"

module tut_io_regs import tut_bus_pkg::*, tut_map_pkg::*; (
	input  logic                       clk_49m,
	input  logic                       reset,
	input  logic                       cen_6m_i,
	input  logic                       cen_3m_i,
	input  cpu_bus_t                   bus_i,
	input  sel_t                       sel_i,
	input  logic                       vblank_irq_i,   // VBlank NMI request
	output logic [`TUT_BANK_SEL_W-1:0] bank_o,
	output board_ctrl_t                ctrl_o,
	output logic                       n_nmi_o,        // Active low to the CPU
	output sound_t                     sound_o
);

	logic [`TUT_BANK_SEL_W-1:0] bank_q;
	logic [`TUT_DATA_W-1:0]     scroll_q;
	logic                       mask_q, flip_q, snd_irq_en_q, pix_en_q;
	logic                       n_nmi_q;
	logic                       snd_irq_q;

	//============================================================
	// Bank select and scroll
	//============================================================
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			bank_q <= '0;
		end else if (cen_3m_i && sel_i.bank_sel) begin
			bank_q <= bus_i.wdata[`TUT_BANK_SEL_W-1:0];     // Low nibble picks the bank
		end
	end

	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			scroll_q <= '0;
		end else if (cen_6m_i && sel_i.scroll && !bus_i.rnw) begin
			scroll_q <= bus_i.wdata;
		end
	end

	// Main latch, A3-A1 address the bit, D0 is the value
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			mask_q       <= 1'b0;
			flip_q       <= 1'b0;
			snd_irq_en_q <= 1'b0;
			pix_en_q     <= 1'b0;
		end else if (cen_3m_i && sel_i.latch) begin
			case (bus_i.addr[3:1])
				3'd0:    mask_q       <= bus_i.wdata[0];  // NMI enable
				3'd1:    flip_q       <= bus_i.wdata[0];
				3'd2:    snd_irq_en_q <= bus_i.wdata[0];  // Sound CPU IRQ
				3'd4:    pix_en_q     <= bus_i.wdata[0];
				default: ;                                // Unused latch bits
			endcase
		end
	end

	//============================================================
	// NMI and sound
	//============================================================
	// Clearing the mask is the only way out of a pending NMI
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			n_nmi_q <= 1'b1;
		end else if (cen_6m_i) begin
			if (!mask_q)
				n_nmi_q <= 1'b1;
			else if (vblank_irq_i)
				n_nmi_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			snd_irq_q <= 1'b0;
		end else if (cen_3m_i) begin
			snd_irq_q <= snd_irq_en_q;
		end
	end

	assign bank_o  = bank_q;
	assign ctrl_o  = '{nmi_mask: mask_q, flip: flip_q, pix_en: pix_en_q, scroll: scroll_q};
	assign n_nmi_o = n_nmi_q;
	assign sound_o = '{cmd: sel_i.snd_cmd, irq: snd_irq_q};     // Command strobe is direct

	// A masked-off NMI is released by the next pixel enable
	a_nmi_mask: assert property (@(posedge clk_49m) disable iff (!reset)
		(!n_nmi_q && !mask_q) |-> ##[1:8] n_nmi_q);

endmodule

// File: verilog/tut_main_board.sv
/* Main board top level
   Clock enables, decoder, control registers, work RAMs, palette, banked ROM */

`timescale 1ns/1ps

`include "tut_board_cfg.svh"

module tut_main_board import tut_bus_pkg::*, tut_map_pkg::*; (
	input  logic                     clk_49m,
	input  logic                     reset,
	input  logic                     pause_i,
	input  cpu_bus_t                 bus_i,         // Held for a whole bus cycle
	input  dl_port_t                 dl_i,          // ROM download
	input  logic [2*`TUT_DATA_W-1:0] dip_sw_i,
	input  logic                     vblank_irq_i,
	output logic [`TUT_DATA_W-1:0]   rd_data_o,
	output cpu_clk_t                 cpu_clk_o,
	output logic                     cen_6m_o,
	output board_ctrl_t              ctrl_o,
	output logic                     n_nmi_o,
	output sound_t                   sound_o
);

	logic                       cen_3m;
	sel_t                       sel;
	logic [`TUT_BANK_SEL_W-1:0] bank;
	logic [`TUT_DATA_W-1:0]     wram_d, wram2_d, pal_d, bank_d;

	tut_clock_gen clock_gen_i (
		.clk_49m (clk_49m), .reset (reset), .pause_i (pause_i),
		.cen_6m_o (cen_6m_o), .cen_3m_o (cen_3m), .cpu_clk_o (cpu_clk_o)
	);

	tut_bus_decode bus_decode_i (
		.clk_49m (clk_49m), .reset (reset), .bus_i (bus_i), .dip_sw_i (dip_sw_i),
		.scroll_i (ctrl_o.scroll), .wram_d_i (wram_d), .wram2_d_i (wram2_d),
		.pal_d_i (pal_d), .bank_d_i (bank_d), .sel_o (sel), .rd_data_o (rd_data_o)
	);

	tut_io_regs io_regs_i (
		.clk_49m (clk_49m), .reset (reset), .cen_6m_i (cen_6m_o), .cen_3m_i (cen_3m),
		.bus_i (bus_i), .sel_i (sel), .vblank_irq_i (vblank_irq_i), .bank_o (bank),
		.ctrl_o (ctrl_o), .n_nmi_o (n_nmi_o), .sound_o (sound_o)
	);

	// Banked ROM at 0x9000, offset straight from the CPU address
	tut_bank_rom bank_rom_i (
		.clk_49m (clk_49m), .dl_i (dl_i), .bank_i (bank),
		.offset_i (bus_i.addr[`TUT_BANK_AW-1:0]), .rdata_o (bank_d)
	);

	// Work RAM 0x8000, I/O windows already masked out of sel.wram
	tut_sync_ram #(.ADDR_W (`TUT_WRAM_AW)) wram_i (
		.clk_49m (clk_49m), .we_i (sel.wram & ~bus_i.rnw),
		.addr_i (bus_i.addr[`TUT_WRAM_AW-1:0]), .wdata_i (bus_i.wdata), .rdata_o (wram_d)
	);

	tut_sync_ram #(.ADDR_W (`TUT_WRAM_AW)) wram2_i (      // Work RAM 2 at 0x8800
		.clk_49m (clk_49m), .we_i (sel.wram2 & ~bus_i.rnw),
		.addr_i (bus_i.addr[`TUT_WRAM_AW-1:0]), .wdata_i (bus_i.wdata), .rdata_o (wram2_d)
	);

	tut_sync_ram #(.ADDR_W (`TUT_PAL_AW)) pal_i (         // 16-byte palette
		.clk_49m (clk_49m), .we_i (sel.pal & ~bus_i.rnw),
		.addr_i (bus_i.addr[`TUT_PAL_AW-1:0]), .wdata_i (bus_i.wdata), .rdata_o (pal_d)
	);

endmodule

// File: test/tb_main_board.sv
/* Main board testbench
   Bus and download tasks, shadow-model reference read, compare process, timeout */

`timescale 1ns/1ps

`include "tut_board_cfg.svh"

module tb_main_board import tut_bus_pkg::*, tut_map_pkg::*; ();

	localparam int BUS_CYC     = 16;     // Clocks per CPU bus cycle
	localparam int TIMEOUT_CYC = 20000;  // Tests need about 3200 cycles, six times margin

	logic                     clk_49m;
	logic                     reset;
	logic                     pause;
	cpu_bus_t                 bus;
	dl_port_t                 dl;
	logic [2*`TUT_DATA_W-1:0] dip_sw;
	logic                     vblank_irq;
	logic [`TUT_DATA_W-1:0]   rd_data;
	cpu_clk_t                 cpu_clk;
	logic                     cen_6m;
	board_ctrl_t              ctrl;
	logic                     n_nmi;
	sound_t                   sound;

	// Shadow copies of everything the CPU can read back
	logic [7:0] wram_sh  [2**`TUT_WRAM_AW];
	logic [7:0] wram2_sh [2**`TUT_WRAM_AW];
	logic [7:0] pal_sh   [2**`TUT_PAL_AW];
	logic [7:0] rom_sh   [2**`TUT_ADDR_W];   // Indexed by download address
	logic [7:0] scroll_sh;
	logic [3:0] bank_sh;

	integer     seed = 87;
	int         cycles = 0;
	int         errors = 0;
	int         checks = 0;
	int         test_err = 0;
	string      name_q[$];                   // Pending compares
	logic [7:0] exp_q[$];
	logic [7:0] act_q[$];

	tut_main_board tut_main_board_i (
		.clk_49m (clk_49m), .reset (reset), .pause_i (pause), .bus_i (bus), .dl_i (dl),
		.dip_sw_i (dip_sw), .vblank_irq_i (vblank_irq), .rd_data_o (rd_data),
		.cpu_clk_o (cpu_clk), .cen_6m_o (cen_6m), .ctrl_o (ctrl), .n_nmi_o (n_nmi),
		.sound_o (sound)
	);

	initial begin
		clk_49m = 1'b0;
		forever #50 clk_49m = ~clk_49m;      // 100 ns period
	end

	always @(posedge clk_49m) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC) begin
			$display("Run stopped after %0d cycles, a test never finished", cycles);
			$display("Errors found");
			$finish;
		end
	end

	// Compare process, drains everything queued on the previous falling edge
	always @(posedge clk_49m) begin
		while (exp_q.size() > 0) begin
			checks = checks + 1;
			if (exp_q[0] !== act_q[0]) begin
				$display("[FAIL] %s: expected %02h, actual %02h", name_q[0], exp_q[0], act_q[0]);
				errors = errors + 1;
			end
			name_q.delete(0);
			exp_q.delete(0);
			act_q.delete(0);
		end
	end

	//============================================================
	// Reference model
	//============================================================
	// I/O windows that hide work RAM
	function automatic logic io_window(input logic [15:0] a);
		io_window = (a[15:4] inside {12'h800, 12'h810, 12'h812, 12'h816, 12'h818, 12'h81A,
		                             12'h81C, 12'h81E})
		         || (a[15:4] == 12'h820)                   // Latch 0x8200-0x820F
		         || (a[15:8] inside {8'h83, 8'h87});       // Bank select, sound command
	endfunction

	function automatic logic [7:0] ref_read(input logic [15:0] a);
		if (a[15:4] == 12'h800)       ref_read = pal_sh[a[3:0]];
		else if (a[15:4] == 12'h810)  ref_read = scroll_sh;
		else if (a[15:4] == 12'h816)  ref_read = ~dip_sw[15:8];   // DSW2, active low
		else if (a[15:4] == 12'h81E)  ref_read = ~dip_sw[7:0];    // DSW1
		else if (io_window(a))        ref_read = 8'hFF;           // Inputs, watchdog, write-only
		else if (a[15:11] == 5'h10)   ref_read = wram_sh[a[10:0]];
		else if (a[15:11] == 5'h11)   ref_read = wram2_sh[a[10:0]];
		else if (a[15:12] == 4'h9)
			ref_read = (bank_sh >= `TUT_BANK_CNT) ? 8'hFF : rom_sh[{bank_sh, a[11:0]}];
		else                          ref_read = 8'hFF;           // ROM and video windows
	endfunction

	task automatic shadow_write(input logic [15:0] a, input logic [7:0] d);
		if (a[15:4] == 12'h800)                      pal_sh[a[3:0]] = d;
		else if (a[15:4] == 12'h810)                 scroll_sh = d;
		else if (a[15:8] == 8'h83)                   bank_sh = d[3:0];
		else if (!io_window(a) && a[15:11] == 5'h10) wram_sh[a[10:0]] = d;
		else if (a[15:11] == 5'h11)                  wram2_sh[a[10:0]] = d;
	endtask

	//============================================================
	// Bus helpers, all entered just after a falling edge
	//============================================================
	task automatic expect_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
	endtask

	task automatic report(input string msg);
		$display("%s", msg);
		errors = errors + 1;
	endtask

	task automatic bus_idle();
		bus = '{addr: 16'h0000, wdata: 8'h00, rnw: 1'b1};   // Open video window
	endtask

	task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
		bus = '{addr: a, wdata: d, rnw: 1'b0};
		shadow_write(a, d);
		repeat (BUS_CYC) @(negedge clk_49m);
		bus_idle();
	endtask

	task automatic bus_read(input string name, input logic [15:0] a);
		bus = '{addr: a, wdata: 8'h00, rnw: 1'b1};
		@(negedge clk_49m);                     // One rising edge through the read path
		expect_byte($sformatf("%s %04h", name, a), ref_read(a), rd_data);
		repeat (BUS_CYC - 1) @(negedge clk_49m);
	endtask

	task automatic download(input logic [15:0] a, input logic [7:0] d);
		dl = '{addr: a, data: d, wr: 1'b1};
		rom_sh[a] = d;
		@(negedge clk_49m);
		dl.wr = 1'b0;
	endtask

	task automatic end_test(input string name);
		@(posedge clk_49m);
		@(negedge clk_49m);                     // Compare queue is empty here
		$display("Test %-8s done, %0d errors", name, errors - test_err);
		test_err = errors;
	endtask

	//============================================================
	// Tests
	//============================================================
	task automatic test_clock();
		logic     e_s [64];
		logic     q_s [64];
		int       pulses;
		int       high;
		logic     stable;
		cpu_clk_t held;
		pulses = 0;
		for (int i = 0; i < 64; i++) begin
			@(negedge clk_49m);
			pulses += cen_6m;
			e_s[i] = cpu_clk.e;
			q_s[i] = cpu_clk.q;
		end
		expect_byte("cen_6m pulses in 64", 8'd8, 8'(pulses));
		for (int w = 1; w < 4; w++) begin
			high = 0;
			for (int i = 16 * w; i < 16 * w + 16; i++)
				high += e_s[i];
			expect_byte($sformatf("E high in period %0d", w), 8'd8, 8'(high));
		end
		for (int i = 1; i < 60; i++)
			if (e_s[i] != e_s[i-1])                         // Q follows E by a quarter
				expect_byte($sformatf("Q step after E at %0d", i), 8'd1, q_s[i+4] != q_s[i+3]);
		pause = 1'b1;
		held = cpu_clk;
		stable = 1'b1;
		repeat (32) begin
			@(negedge clk_49m);
			if (cpu_clk != held)
				stable = 1'b0;
		end
		pause = 1'b0;
		expect_byte("E/Q held in pause", 8'd1, stable);
	endtask

	task automatic test_memory();
		logic [15:0] wa [8];
		logic [15:0] wa2 [8];
		logic [15:0] pa [8];
		for (int i = 0; i < 8; i++) begin
			wa[i]  = 16'h8400 | 16'($random(seed) & 32'h2FF);  // Clear of all I/O windows
			wa2[i] = 16'h8800 | 16'($random(seed) & 32'h7FF);
			pa[i]  = 16'h8000 | 16'($random(seed) & 32'h00F);
			bus_write(wa[i], 8'($random(seed)));
			bus_write(wa2[i], 8'($random(seed)));
			bus_write(pa[i], 8'($random(seed)));
		end
		for (int i = 0; i < 8; i++) begin
			bus_read("work RAM", wa[i]);
			bus_read("work RAM 2", wa2[i]);
			bus_read("palette", pa[i]);
		end
		bus_write(16'h8100, 8'($random(seed)));
		expect_byte("scroll output", scroll_sh, ctrl.scroll);
		bus_read("scroll", 16'h8100);
		bus_write(16'h8010, 8'h3C);              // Work RAM just above the palette
		bus_write(16'h8000, 8'hC3);              // Palette wins at 0x8000
		bus_read("work RAM after palette", 16'h8010);
		bus_read("palette over work RAM", 16'h8000);
	endtask

	task automatic test_banks();
		logic [11:0] offs [9][8];
		for (int b = 0; b < `TUT_BANK_CNT; b++)
			for (int i = 0; i < 8; i++) begin
				offs[b][i] = 12'($random(seed));
				download({4'(b), offs[b][i]}, 8'($random(seed)));
			end
		for (int b = 0; b < `TUT_BANK_CNT; b++) begin
			bus_write(16'h8300, 8'(b));
			for (int i = 0; i < 8; i++)
				bus_read($sformatf("bank %0d", b), 16'h9000 | 16'(offs[b][i]));
		end
		for (int b = `TUT_BANK_CNT; b < 16; b++) begin  // No ROM fitted
			bus_write(16'h8300, 8'(b));
			bus_read($sformatf("empty bank %0d", b), 16'h9000 | 16'($random(seed) & 32'hFFF));
		end
	endtask

	task automatic test_inputs();
		dip_sw = 16'($random(seed));
		bus_read("DSW1", 16'h81E0);
		bus_read("DSW2", 16'h8160);
		bus_read("IN0", 16'h8180);
		bus_read("IN1", 16'h81A0);
		bus_read("IN2", 16'h81C0);
		bus_read("watchdog", 16'h8120);
		bus_read("main ROM", 16'hA000);
		bus_read("main ROM", 16'hFFFF);
		bus_read("video", 16'h0000);
		bus_read("video", 16'h4000);
	endtask

	task automatic test_latch();
		int n;
		bus_write(16'h8202, 8'h01);              // Latch bit 1
		expect_byte("flip", 8'd1, ctrl.flip);
		bus_write(16'h8208, 8'h01);              // Latch bit 4, A3 set
		expect_byte("pixel enable", 8'd1, ctrl.pix_en);
		bus_read("latch reads open bus", 16'h8208);
		bus_write(16'h8200, 8'h01);              // NMI mask on
		expect_byte("nmi mask", 8'd1, ctrl.nmi_mask);
		expect_byte("n_nmi idle", 8'd1, n_nmi);
		vblank_irq = 1'b1;
		n = 0;
		while (n_nmi !== 1'b0 && n < 16) begin
			@(negedge clk_49m);
			n++;
		end
		if (n_nmi !== 1'b0)
			report("n_nmi_o did not go low within 16 cycles of VBlank");
		vblank_irq = 1'b0;
		repeat (BUS_CYC) @(negedge clk_49m);
		expect_byte("n_nmi held", 8'd0, n_nmi);
		bus_write(16'h8200, 8'h00);              // Mask off releases it
		n = 0;
		while (n_nmi !== 1'b1 && n < 16) begin
			@(negedge clk_49m);
			n++;
		end
		if (n_nmi !== 1'b1)
			report("n_nmi_o stayed low after the NMI mask was cleared");
		expect_byte("sound cmd idle", 8'd0, sound.cmd);
		bus = '{addr: 16'h8700, wdata: 8'h5A, rnw: 1'b0};
		@(negedge clk_49m);
		expect_byte("sound cmd strobe", 8'd1, sound.cmd);
		repeat (BUS_CYC - 1) @(negedge clk_49m);
		bus_idle();
		@(negedge clk_49m);
		expect_byte("sound cmd release", 8'd0, sound.cmd);
		bus_write(16'h8204, 8'h01);              // Latch bit 2, sound IRQ
		n = 0;
		while (sound.irq !== 1'b1 && n < 2 * BUS_CYC) begin
			@(negedge clk_49m);
			n++;
		end
		if (sound.irq !== 1'b1)
			report("sound IRQ trigger did not follow latch bit 2 going high");
		bus_write(16'h8204, 8'h00);
		n = 0;
		while (sound.irq !== 1'b0 && n < 2 * BUS_CYC) begin
			@(negedge clk_49m);
			n++;
		end
		if (sound.irq !== 1'b0)
			report("sound IRQ trigger did not follow latch bit 2 going low");
	endtask

	initial begin
		reset      = 1'b0;
		pause      = 1'b0;
		dl         = '0;
		dip_sw     = '0;
		vblank_irq = 1'b0;
		scroll_sh  = 8'h00;                      // Register reset values
		bank_sh    = 4'h0;
		bus_idle();
		repeat (8) @(negedge clk_49m);
		reset = 1'b1;
		test_clock();
		end_test("clock");
		test_memory();
		end_test("memory");
		test_banks();
		end_test("banks");
		test_inputs();
		end_test("inputs");
		test_latch();
		end_test("latch");
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+common
common/tut_bus_pkg.sv
common/tut_map_pkg.sv
verilog/tut_clock_gen.sv
memory/tut_sync_ram.sv
memory/tut_bank_rom.sv
verilog/tut_bus_decode.sv
verilog/tut_io_regs.sv
verilog/tut_main_board.sv
test/tb_main_board.sv

// File: Bender.yml
package:
  name: tut_main_board

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/tut_bus_pkg.sv
      - common/tut_map_pkg.sv
      - verilog/tut_clock_gen.sv
      - memory/tut_sync_ram.sv
      - memory/tut_bank_rom.sv
      - verilog/tut_bus_decode.sv
      - verilog/tut_io_regs.sv
      - verilog/tut_main_board.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/tb_main_board.sv
